//--- build.f
+incdir+src
src/lsu_pkg.sv
src/mem_req_gen.sv
src/commit_counter.sv
src/stage_reg.sv
src/load_extend.sv
src/mem_stage_top.sv
bench/mem_stage_assert.sv
bench/mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000000

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) src/lsu_cfg.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/mem_stage_tb.sv
module mem_stage_tb
    import lsu_pkg::*;
();

    localparam int NUM_TXN    = 400;
    localparam int WAIT_LIMIT = 50;

    logic        clk;
    logic        rst;
    logic        load_i;
    logic        flush_i;
    logic        squash_commit_i;
    logic        read_i;
    logic        write_i;
    logic [2:0]  funct3_i;
    word_t       addr_i;
    word_t       store_data_i;
    logic        mem_resp_i;
    word_t       rdata_i;
    logic        req_valid_o;
    logic        mem_read_o;
    logic        mem_write_o;
    word_t       mem_addr_o;
    logic [3:0]  mem_byte_en_o;
    word_t       mem_wdata_o;
    order_t      req_order_o;
    logic        wb_valid_o;
    word_t       wb_data_o;
    order_t      wb_order_o;
    int unsigned timeouts;

    mem_stage_top dut0 (.*);

    always #5 clk = ~clk;

    task automatic wait_req_valid();
        int cycles;
        cycles = 0;
        while (!req_valid_o && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!req_valid_o) begin
            timeouts++;
            $display("timeout while waiting for req_valid_o");
        end
    endtask

    task automatic wait_wb_valid();
        int cycles;
        cycles = 0;
        while (!wb_valid_o && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_valid_o) begin
            timeouts++;
            $display("timeout while waiting for wb_valid_o");
        end
    endtask

    task automatic pulse_response();
        mem_resp_i = 1'b1;
        rdata_i    = $urandom;
        @(negedge clk);
        mem_resp_i = 1'b0;
    endtask

    // one load strobe and the response for a kept read
    task automatic issue_request(input logic with_flush, input logic with_squash);
        logic       is_write;
        logic [2:0] f3;
        is_write = 1'($urandom % 2);
        if (is_write && ($urandom % 8) != 0) begin
            f3 = 3'($urandom % 3);  // sb, sh, sw
        end else begin
            f3 = 3'($urandom % 8);  // any code including undefined ones
        end
        load_i          = 1'b1;
        read_i          = !is_write;
        write_i         = is_write;
        funct3_i        = f3;
        addr_i          = $urandom;
        store_data_i    = $urandom;
        flush_i         = with_flush;
        squash_commit_i = with_squash;
        @(negedge clk);
        load_i          = 1'b0;
        flush_i         = 1'b0;
        squash_commit_i = 1'b0;
        if (!with_flush && !is_write) begin
            wait_req_valid();
            pulse_response();
            wait_wb_valid();
        end else if (($urandom % 4) == 0) begin
            pulse_response();  // no held read to take it
        end
    endtask

    task automatic pulse_flush(input logic with_squash);
        flush_i         = 1'b1;
        squash_commit_i = with_squash;
        @(negedge clk);
        flush_i         = 1'b0;
        squash_commit_i = 1'b0;
    endtask

    initial begin
        int unsigned sel;
        void'($urandom(32'h2ecb8e83));
        clk             = 1'b0;
        rst             = 1'b0;
        load_i          = 1'b0;
        flush_i         = 1'b0;
        squash_commit_i = 1'b0;
        read_i          = 1'b0;
        write_i         = 1'b0;
        funct3_i        = '0;
        addr_i          = '0;
        store_data_i    = '0;
        mem_resp_i      = 1'b0;
        rdata_i         = '0;
        timeouts        = 0;
        #1 rst = 1'b1;  // edge for the async reset
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < NUM_TXN; i++) begin
            sel = $urandom % 16;
            if (sel == 0) begin
                issue_request(1'b1, 1'($urandom % 2));  // flush beats load
            end else if (sel == 1) begin
                pulse_flush(1'($urandom % 2));
            end else begin
                issue_request(1'b0, 1'b0);
            end
        end
        repeat (3) @(negedge clk);
        $display("errors: %0d assertion failures, %0d timeouts", dut0.chk0.fail_cnt, timeouts);
        if (dut0.chk0.fail_cnt == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : mem_stage_tb

//--- bench/mem_stage_assert.sv
`include "lsu_cfg.svh"

module mem_stage_assert
    import lsu_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       load_i,
    input logic       flush_i,
    input logic       squash_commit_i,
    input logic       read_i,
    input logic       write_i,
    input logic [2:0] funct3_i,
    input word_t      addr_i,
    input word_t      store_data_i,
    input logic       mem_resp_i,
    input word_t      rdata_i,
    input logic       req_valid_o,
    input logic       mem_read_o,
    input logic       mem_write_o,
    input word_t      mem_addr_o,
    input logic [3:0] mem_byte_en_o,
    input word_t      mem_wdata_o,
    input order_t     req_order_o,
    input logic       wb_valid_o,
    input word_t      wb_data_o,
    input order_t     wb_order_o
);

    typedef logic [`LSU_LANES-1:0] be_t;

    int unsigned fail_cnt = 0;

    logic       acc_q;
    logic       held_valid;
    logic       held_read;
    logic       held_write;
    logic [2:0] held_f3;
    lane_t      held_off;
    order_t     next_order;  // number the next accepted request should carry
    order_t     exp_order_q;
    word_t      exp_addr_q;
    be_t        exp_be_q;
    word_t      exp_wdata_q;
    logic       chk_addr_q;
    logic       chk_wdata_q;
    logic       resp_q;
    logic       chk_wb_q;
    word_t      exp_wb_data_q;
    order_t     exp_wb_order_q;
    logic [1:0] cur_size;
    lane_t      cur_off;

    // 0 none, 1 byte, 2 half, 3 word
    function automatic logic [1:0] access_size(input logic [2:0] f3, input logic is_store);
        case (f3)
            `LSU_F3_B:  return 2'd1;
            `LSU_F3_H:  return 2'd2;
            `LSU_F3_W:  return 2'd3;
            `LSU_F3_BU: return is_store ? 2'd0 : 2'd1;
            `LSU_F3_HU: return is_store ? 2'd0 : 2'd2;
            default:    return 2'd0;
        endcase
    endfunction

    function automatic be_t lane_enables(input logic [1:0] size, input lane_t off);
        case (size)
            2'd1:    return be_t'(1) << off;
            2'd2:    return be_t'(3) << off;
            2'd3:    return '1;
            default: return '0;
        endcase
    endfunction

    function automatic word_t load_result(input word_t w, input logic [2:0] f3, input lane_t off);
        word_t shifted;
        shifted = w >> (8 * off);
        case (f3)
            `LSU_F3_B:  return word_t'($signed(shifted[7:0]));
            `LSU_F3_H:  return word_t'($signed(shifted[15:0]));
            `LSU_F3_BU: return word_t'(shifted[7:0]);
            `LSU_F3_HU: return word_t'(shifted[15:0]);
            default:    return w;
        endcase
    endfunction

    assign cur_size = access_size(funct3_i, write_i);
    assign cur_off  = (cur_size == 2'd1 || cur_size == 2'd2) ? lane_t'(addr_i) : '0;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            acc_q          <= 1'b0;
            held_valid     <= 1'b0;
            held_read      <= 1'b0;
            held_write     <= 1'b0;
            held_f3        <= '0;
            held_off       <= '0;
            next_order     <= '0;
            exp_order_q    <= '0;
            exp_addr_q     <= '0;
            exp_be_q       <= '0;
            exp_wdata_q    <= '0;
            chk_addr_q     <= 1'b0;
            chk_wdata_q    <= 1'b0;
            resp_q         <= 1'b0;
            chk_wb_q       <= 1'b0;
            exp_wb_data_q  <= '0;
            exp_wb_order_q <= '0;
        end else begin
            acc_q          <= load_i && !flush_i;
            resp_q         <= mem_resp_i && held_valid && held_read;
            chk_wb_q       <= access_size(held_f3, 1'b0) != 2'd0;
            exp_wb_data_q  <= load_result(rdata_i, held_f3, held_off);
            exp_wb_order_q <= exp_order_q;
            if (flush_i) begin
                held_valid <= 1'b0;
                if (squash_commit_i) begin
                    next_order <= next_order - order_t'(1);  // number given back
                end
            end else if (load_i) begin
                held_valid  <= 1'b1;
                held_read   <= read_i;
                held_write  <= write_i;
                held_f3     <= funct3_i;
                held_off    <= cur_off;
                exp_order_q <= next_order;
                next_order  <= next_order + order_t'(1);
                exp_addr_q  <= (cur_size == 2'd3) ? addr_i : (addr_i & ~word_t'(`LSU_LANES - 1));
                exp_be_q    <= lane_enables(cur_size, cur_off);
                exp_wdata_q <= store_data_i << (8 * cur_off);
                chk_addr_q  <= cur_size != 2'd0;
                chk_wdata_q <= write_i && cur_size != 2'd0;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) (rst || $past(rst)) |->
        (!req_valid_o && !wb_valid_o && !mem_read_o && !mem_write_o && mem_byte_en_o == '0))
        else begin
            fail_cnt++;
            $error("outputs are not idle during or right after reset");
        end

    a_req_flags: assert property (@(posedge clk) disable iff (rst) acc_q |->
        {req_valid_o, mem_read_o, mem_write_o} == {1'b1, held_read, held_write})
        else begin
            fail_cnt++;
            $error("Mismatch req_valid_o/mem_read_o/mem_write_o: got %h expected %h",
                $sampled({req_valid_o, mem_read_o, mem_write_o}),
                $sampled({1'b1, held_read, held_write}));
        end

    a_req_addr: assert property (@(posedge clk) disable iff (rst)
        acc_q && chk_addr_q |-> mem_addr_o == exp_addr_q)
        else begin
            fail_cnt++;
            $error("Mismatch mem_addr_o: got %h expected %h",
                $sampled(mem_addr_o), $sampled(exp_addr_q));
        end

    a_req_byte_en: assert property (@(posedge clk) disable iff (rst)
        acc_q |-> mem_byte_en_o == exp_be_q)
        else begin
            fail_cnt++;
            $error("Mismatch mem_byte_en_o: got %h expected %h",
                $sampled(mem_byte_en_o), $sampled(exp_be_q));
        end

    a_req_wdata: assert property (@(posedge clk) disable iff (rst)
        acc_q && chk_wdata_q |-> mem_wdata_o == exp_wdata_q)
        else begin
            fail_cnt++;
            $error("Mismatch mem_wdata_o: got %h expected %h",
                $sampled(mem_wdata_o), $sampled(exp_wdata_q));
        end

    a_req_order: assert property (@(posedge clk) disable iff (rst)
        acc_q |-> req_order_o == exp_order_q)
        else begin
            fail_cnt++;
            $error("Mismatch req_order_o: got %h expected %h",
                $sampled(req_order_o), $sampled(exp_order_q));
        end

    a_flush_drop: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> !req_valid_o && !mem_read_o && !mem_write_o)
        else begin
            fail_cnt++;
            $error("request still valid in the cycle after a flush");
        end

    a_wb_pulse: assert property (@(posedge clk) disable iff (rst) wb_valid_o == resp_q)
        else begin
            fail_cnt++;
            $error("Mismatch wb_valid_o: got %h expected %h",
                $sampled(wb_valid_o), $sampled(resp_q));
        end

    a_wb_order: assert property (@(posedge clk) disable iff (rst)
        resp_q |-> wb_order_o == exp_wb_order_q)
        else begin
            fail_cnt++;
            $error("Mismatch wb_order_o: got %h expected %h",
                $sampled(wb_order_o), $sampled(exp_wb_order_q));
        end

    a_wb_data: assert property (@(posedge clk) disable iff (rst)
        resp_q && chk_wb_q |-> wb_data_o == exp_wb_data_q)
        else begin
            fail_cnt++;
            $error("Mismatch wb_data_o: got %h expected %h",
                $sampled(wb_data_o), $sampled(exp_wb_data_q));
        end

endmodule : mem_stage_assert

bind mem_stage_top mem_stage_assert chk0 (.*);

//--- src/mem_stage_top.sv
module mem_stage_top
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load_i,
    input  logic       flush_i,
    input  logic       squash_commit_i,
    input  logic       read_i,
    input  logic       write_i,
    input  logic [2:0] funct3_i,
    input  word_t      addr_i,
    input  word_t      store_data_i,
    input  logic       mem_resp_i,
    input  word_t      rdata_i,
    output logic       req_valid_o,
    output logic       mem_read_o,
    output logic       mem_write_o,
    output word_t      mem_addr_o,
    output logic [3:0] mem_byte_en_o,
    output word_t      mem_wdata_o,
    output order_t     req_order_o,
    output logic       wb_valid_o,
    output word_t      wb_data_o,
    output order_t     wb_order_o
);

    word_t        gen_addr;
    logic [3:0]   gen_byte_en;
    word_t        gen_wdata;
    lane_t        gen_lane;
    order_t       next_order;
    logic         cnt_step;
    logic         cnt_give_back;
    req_payload_t req_d;
    req_payload_t req_q;
    logic         req_valid;
    word_t        ext_data;
    logic         wb_capture;
    wb_payload_t  wb_d;
    wb_payload_t  wb_q;

    mem_req_gen u_gen (
        .read_i       (read_i),
        .write_i      (write_i),
        .funct3_i     (funct3_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .addr_o       (gen_addr),
        .byte_en_o    (gen_byte_en),
        .wdata_o      (gen_wdata),
        .lane_o       (gen_lane)
    );

    // flush beats load, a squashed flush returns the number
    assign cnt_step      = load_i && !flush_i;
    assign cnt_give_back = flush_i && squash_commit_i;

    commit_counter u_cnt (
        .clk         (clk),
        .rst         (rst),
        .step_i      (cnt_step),
        .give_back_i (cnt_give_back),
        .order_o     (next_order)
    );

    always_comb begin : req_pack
        req_d.addr    = gen_addr;
        req_d.byte_en = gen_byte_en;
        req_d.wdata   = gen_wdata;
        req_d.read    = read_i;
        req_d.write   = write_i;
        req_d.funct3  = funct3_i;
        req_d.lane    = gen_lane;
        req_d.order   = next_order;
    end

    stage_reg #(
        .payload_t (req_payload_t)
    ) u_req (
        .clk       (clk),
        .rst       (rst),
        .load_i    (load_i),
        .clear_i   (flush_i),
        .payload_i (req_d),
        .valid_o   (req_valid),
        .payload_o (req_q)
    );

    assign req_valid_o   = req_valid;
    assign mem_read_o    = req_valid && req_q.read;
    assign mem_write_o   = req_valid && req_q.write;
    assign mem_addr_o    = req_q.addr;
    assign mem_byte_en_o = req_q.byte_en;
    assign mem_wdata_o   = req_q.wdata;
    assign req_order_o   = req_q.order;

    // response path uses the held access size and lane
    load_extend u_ext (
        .rdata_i  (rdata_i),
        .funct3_i (req_q.funct3),
        .lane_i   (req_q.lane),
        .data_o   (ext_data)
    );

    // only a held read takes the response
    assign wb_capture = mem_resp_i && mem_read_o;

    always_comb begin : wb_pack
        wb_d.data  = ext_data;
        wb_d.order = req_q.order;
    end

    stage_reg #(
        .payload_t (wb_payload_t)
    ) u_wb (
        .clk       (clk),
        .rst       (rst),
        .load_i    (wb_capture),
        .clear_i   (!wb_capture),  // single cycle pulse
        .payload_i (wb_d),
        .valid_o   (wb_valid_o),
        .payload_o (wb_q)
    );

    assign wb_data_o  = wb_q.data;
    assign wb_order_o = wb_q.order;

endmodule : mem_stage_top

//--- src/load_extend.sv
`include "lsu_cfg.svh"

module load_extend
    import lsu_pkg::*;
(
    input  word_t      rdata_i,
    input  logic [2:0] funct3_i,
    input  lane_t      lane_i,
    output word_t      data_o
);

    word_t      lane_word;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // bring the addressed lane down to bit 0
    assign lane_word = rdata_i >> {lane_i, 3'b000};
    assign lane_byte = lane_word[7:0];
    assign lane_half = lane_word[15:0];

    always_comb begin
        case (funct3_i)
            `LSU_F3_B: begin
                data_o = {{(`LSU_XLEN-8){lane_byte[7]}}, lane_byte};
            end
            `LSU_F3_H: begin
                data_o = {{(`LSU_XLEN-16){lane_half[15]}}, lane_half};
            end
            `LSU_F3_BU: begin
                data_o = {{(`LSU_XLEN-8){1'b0}}, lane_byte};
            end
            `LSU_F3_HU: begin
                data_o = {{(`LSU_XLEN-16){1'b0}}, lane_half};
            end
            default: begin
                data_o = rdata_i;  // lw takes the whole word
            end
        endcase
    end

endmodule : load_extend

//--- src/stage_reg.sv
module stage_reg
    import lsu_pkg::*;
#(
    parameter type payload_t = word_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load_i,
    input  logic     clear_i,
    input  payload_t payload_i,
    output logic     valid_o,
    output payload_t payload_o
);

    // clear has priority over load
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            valid_o   <= 1'b0;
            payload_o <= '0;
        end else if (clear_i) begin
            valid_o   <= 1'b0;
            payload_o <= '0;
        end else if (load_i) begin
            valid_o   <= 1'b1;
            payload_o <= payload_i;
        end
    end

endmodule : stage_reg

//--- src/commit_counter.sv
module commit_counter
    import lsu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   step_i,
    input  logic   give_back_i,
    output order_t order_o
);

    order_t count_q;

    // starts at all ones so the first stamp reads zero
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            count_q <= '1;
        end else if (step_i) begin
            count_q <= count_q + order_t'(1);
        end else if (give_back_i) begin
            count_q <= count_q - order_t'(1);  // squashed request
        end
    end

    // number the next stamped request receives
    assign order_o = count_q + order_t'(1);

endmodule : commit_counter

//--- src/mem_req_gen.sv
`include "lsu_cfg.svh"

module mem_req_gen
    import lsu_pkg::*;
(
    input  logic                  read_i,
    input  logic                  write_i,
    input  logic [2:0]            funct3_i,
    input  word_t                 addr_i,
    input  word_t                 store_data_i,
    output word_t                 addr_o,
    output logic [`LSU_LANES-1:0] byte_en_o,
    output word_t                 wdata_o,
    output lane_t                 lane_o
);

    localparam int LANE_W = $clog2(`LSU_LANES);
    localparam logic [`LSU_LANES-1:0] BYTE_MASK = {{(`LSU_LANES-1){1'b0}}, 1'b1};
    localparam logic [`LSU_LANES-1:0] HALF_MASK = {{(`LSU_LANES-2){1'b0}}, 2'b11};

    logic acc_word;
    logic acc_half;
    logic acc_byte;

    always_comb begin : size_decode
        acc_word = 1'b0;
        acc_half = 1'b0;
        acc_byte = 1'b0;
        if (read_i || write_i) begin
            case (funct3_i)
                `LSU_F3_W:  acc_word = 1'b1;
                `LSU_F3_H:  acc_half = 1'b1;
                `LSU_F3_B:  acc_byte = 1'b1;
                `LSU_F3_HU: acc_half = !write_i;  // no unsigned store
                `LSU_F3_BU: acc_byte = !write_i;
                default:    ;                     // undefined, no enables
            endcase
        end
    end

    always_comb begin : addr_mask
        addr_o    = addr_i;
        lane_o    = '0;
        byte_en_o = '0;
        if (acc_word) begin
            byte_en_o = '1;
        end else if (acc_half || acc_byte) begin
            lane_o    = addr_i[LANE_W-1:0];
            addr_o    = {addr_i[`LSU_XLEN-1:LANE_W], {LANE_W{1'b0}}};
            byte_en_o = (acc_half ? HALF_MASK : BYTE_MASK) << lane_o;
        end
    end

    // store data moves up to its byte lane
    assign wdata_o = write_i ? (store_data_i << {lane_o, 3'b000}) : '0;

endmodule : mem_req_gen

//--- src/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

    // one data or address word
    typedef logic [`LSU_XLEN-1:0] word_t;

    // commit order number
    typedef logic [`LSU_ORDER_W-1:0] order_t;

    // byte offset within a word
    typedef logic [$clog2(`LSU_LANES)-1:0] lane_t;

    // request stage contents
    typedef struct packed {
        word_t                  addr;     // word aligned for sub-word access
        logic [`LSU_LANES-1:0]  byte_en;
        word_t                  wdata;    // already lane shifted
        logic                   read;
        logic                   write;
        logic [2:0]             funct3;
        lane_t                  lane;     // kept for the load return path
        order_t                 order;
    } req_payload_t;

    // writeback contents
    typedef struct packed {
        word_t  data;   // extended load result
        order_t order;
    } wb_payload_t;

endpackage : lsu_pkg

//--- src/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data path and address width
`define LSU_XLEN 32

// commit order counter width
`define LSU_ORDER_W 64

// bytes per word, also the byte enable width
`define LSU_LANES 4

// funct3 access codes, stores use B/H/W only
`define LSU_F3_B  3'd0
`define LSU_F3_H  3'd1
`define LSU_F3_W  3'd2
`define LSU_F3_BU 3'd4
`define LSU_F3_HU 3'd5

`endif
